// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// ========================================================================
	// Vector types of the fetch path
	// ========================================================================

	// Byte address
	// Instructions are halfword aligned and memory words are word aligned
	typedef logic [31:0] addr_t;

	// One memory or cache word
	typedef logic [31:0] word_t;

	// One 16-bit instruction parcel
	typedef logic [15:0] half_t;

	// Whole instruction, compressed ones zero extended
	typedef logic [31:0] instr_t;

	// ========================================================================
	// Instruction length rule
	// ========================================================================

	// Low two bits both set means a 32-bit instruction
	function automatic logic is_32bit_parcel(input half_t parcel);
		return parcel[1:0] == 2'b11;
	endfunction

	// Byte length of the instruction that starts with this parcel
	function automatic addr_t instr_len_bytes(input half_t parcel);
		return is_32bit_parcel(parcel) ? 32'd4 : 32'd2;
	endfunction

endpackage

`default_nettype wire

// File: hw/fetch_bus_master.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_bus_master (
	input  wire                     clk,
	input  wire                     rst_n,
	// Fill port from the cache
	input  wire                     fill_req,
	input  wire fetch_pkg::addr_t   fill_addr,
	output logic                    fill_ack,
	output fetch_pkg::word_t        fill_data,
	// External memory bus
	output logic                    mem_req,
	output fetch_pkg::addr_t        mem_addr,
	input  wire                     mem_ack,
	input  wire fetch_pkg::word_t   mem_rdata
);

	typedef enum logic [1:0] {
		BM_IDLE,
		BM_REQUEST,
		BM_RELEASE,
		BM_FINISH
	} bm_state_t;

	bm_state_t state;

	// ========================================================================
	// Fill to memory bridge
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= BM_IDLE;
			mem_req  <= 1'b0;
			mem_addr <= '0;
			fill_ack <= 1'b0;
		end else begin
			case (state)
				BM_IDLE: begin
					// Memory ack is low since BM_RELEASE closed the last transfer
					if (fill_req) begin
						mem_req  <= 1'b1;
						mem_addr <= fill_addr;
						state    <= BM_REQUEST;
					end
				end
				BM_REQUEST: begin
					// Word arrives with ack and goes to the cache next cycle
					if (mem_ack) begin
						mem_req  <= 1'b0;
						fill_ack <= 1'b1;
						state    <= BM_RELEASE;
					end
				end
				BM_RELEASE: begin
					// Close the memory handshake first
					if (!mem_ack)
						state <= BM_FINISH;
				end
				BM_FINISH: begin
					// Then the fill handshake
					if (!fill_req) begin
						fill_ack <= 1'b0;
						state    <= BM_IDLE;
					end
				end
				default: state <= BM_IDLE;
			endcase
		end
	end

	// Captured word held until the cache drops fill_req
	always_ff @(posedge clk) begin
		if (state == BM_REQUEST && mem_ack)
			fill_data <= mem_rdata;
	end

endmodule

`default_nettype wire

// File: hw/icache_ro_assoc.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ro_assoc #(
	parameter int ICACHE_ENTRIES = 8
) (
	input  wire                     clk,
	input  wire                     rst_n,
	// Word port from the aligner
	input  wire                     word_req,
	input  wire fetch_pkg::addr_t   word_addr,
	output logic                    word_ack,
	output fetch_pkg::word_t        word_data,
	// Fill port to the bus master
	output logic                    fill_req,
	output fetch_pkg::addr_t        fill_addr,
	input  wire                     fill_ack,
	input  wire fetch_pkg::word_t   fill_data
);
	import fetch_pkg::*;

	localparam int IDX_W = $clog2(ICACHE_ENTRIES);

	// Word address used as tag
	typedef logic [29:0] tag_t;

	typedef enum logic [2:0] {
		C_IDLE,
		C_LOOKUP,
		C_FILL,
		C_RESPOND,
		C_RELEASE
	} cache_state_t;

	cache_state_t              state;
	logic [ICACHE_ENTRIES-1:0] line_valid;
	tag_t                      line_tag [ICACHE_ENTRIES];
	word_t                     line_data [ICACHE_ENTRIES];
	// Round-robin victim, moves on fills only
	logic [IDX_W-1:0]          victim;
	tag_t                      req_tag;
	logic                      hit_q;
	logic [IDX_W-1:0]          hit_idx_q;
	logic                      lookup_hit;
	logic [IDX_W-1:0]          lookup_idx;

	// ========================================================================
	// Parallel tag compare
	// ========================================================================

	always_comb begin
		lookup_hit = 1'b0;
		lookup_idx = '0;
		for (int i = 0; i < ICACHE_ENTRIES; i++) begin
			if (line_valid[i] && line_tag[i] == word_addr[31:2]) begin
				lookup_hit = 1'b1;
				lookup_idx = IDX_W'(i);
			end
		end
	end

	assign fill_addr = {req_tag, 2'b00};

	// ========================================================================
	// Control
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= C_IDLE;
			word_ack   <= 1'b0;
			fill_req   <= 1'b0;
			line_valid <= '0;
			victim     <= '0;
			hit_q      <= 1'b0;
		end else begin
			case (state)
				C_IDLE: begin
					// First cycle compares tags
					if (word_req) begin
						hit_q <= lookup_hit;
						state <= C_LOOKUP;
					end
				end
				C_LOOKUP: begin
					// Second cycle registers data on a hit
					if (hit_q) begin
						word_ack <= 1'b1;
						state    <= C_RELEASE;
					end else begin
						fill_req <= 1'b1;
						state    <= C_FILL;
					end
				end
				C_FILL: begin
					if (fill_ack) begin
						fill_req           <= 1'b0;
						line_valid[victim] <= 1'b1;
						victim             <= victim + 1'b1;
						state              <= C_RESPOND;
					end
				end
				C_RESPOND: begin
					// Line installed, answer once the fill closes
					if (!fill_ack) begin
						word_ack <= 1'b1;
						state    <= C_RELEASE;
					end
				end
				C_RELEASE: begin
					if (!word_req) begin
						word_ack <= 1'b0;
						state    <= C_IDLE;
					end
				end
				default: state <= C_IDLE;
			endcase
		end
	end

	// Tags, data and the returned word
	always_ff @(posedge clk) begin
		if (state == C_IDLE && word_req) begin
			req_tag   <= word_addr[31:2];
			hit_idx_q <= lookup_idx;
		end
		if (state == C_LOOKUP && hit_q)
			word_data <= line_data[hit_idx_q];
		if (state == C_FILL && fill_ack) begin
			line_tag[victim]  <= req_tag;
			line_data[victim] <= fill_data;
			word_data         <= fill_data;
		end
	end

endmodule

`default_nettype wire

// File: hw/instr_aligner.sv
`timescale 1ns/100ps
`default_nettype none

module instr_aligner #(
	parameter fetch_pkg::addr_t RESET_PC = '0
) (
	input  wire                     clk,
	input  wire                     rst_n,
	// Fetch restart
	input  wire                     redirect,
	input  wire fetch_pkg::addr_t   redirect_pc,
	// Word port to the cache
	output logic                    word_req,
	output fetch_pkg::addr_t        word_addr,
	input  wire                     word_ack,
	input  wire fetch_pkg::word_t   word_data,
	// Instruction port
	output logic                    instr_req,
	output fetch_pkg::instr_t       instr,
	output fetch_pkg::addr_t        instr_pc,
	output logic                    instr_is_32bit,
	input  wire                     instr_ack
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		AL_IDLE,
		AL_FETCH,
		AL_OUTPUT
	} al_state_t;

	al_state_t state;
	// Address of the instruction being assembled or offered
	addr_t     pc;
	// Next word to fetch
	addr_t     fetch_addr;
	// Parcel at pc when valid
	half_t     hw_buf;
	logic      hw_buf_valid;
	// Word in flight belongs to the old stream
	logic      discard;

	logic      buf_ready;
	logic      start_fetch;
	logic      issue_buf;
	logic      take_word;
	instr_t    asm_instr;
	logic      asm_done;
	logic      asm_buf_valid;

	// Buffered compressed instruction needs no fetch
	assign buf_ready   = hw_buf_valid && !is_32bit_parcel(hw_buf);
	assign start_fetch = state == AL_IDLE && !buf_ready && !word_ack;
	assign issue_buf   = state == AL_IDLE && buf_ready && !instr_ack;
	assign take_word   = state == AL_FETCH && word_ack && !discard && !instr_ack;

	assign instr_pc       = pc;
	assign instr_is_32bit = is_32bit_parcel(instr[15:0]);

	// ========================================================================
	// Assembly from a returned word, little endian
	// ========================================================================

	always_comb begin
		asm_instr     = word_data;
		asm_done      = 1'b1;
		asm_buf_valid = 1'b0;
		if (hw_buf_valid) begin
			// Straddling instruction
			asm_instr     = {word_data[15:0], hw_buf};
			asm_buf_valid = 1'b1;
		end else if (pc[1]) begin
			// Odd halfword start, low half lies before pc
			if (is_32bit_parcel(word_data[31:16]))
				asm_done = 1'b0;
			else
				asm_instr = {16'h0000, word_data[31:16]};
			asm_buf_valid = is_32bit_parcel(word_data[31:16]);
		end else if (!is_32bit_parcel(word_data[15:0])) begin
			asm_instr     = {16'h0000, word_data[15:0]};
			asm_buf_valid = 1'b1;
		end
	end

	// ========================================================================
	// Sequencing
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= AL_IDLE;
			pc           <= RESET_PC;
			fetch_addr   <= {RESET_PC[31:2], 2'b00};
			hw_buf_valid <= 1'b0;
			discard      <= 1'b0;
			word_req     <= 1'b0;
			instr_req    <= 1'b0;
		end else if (redirect) begin
			pc           <= redirect_pc;
			fetch_addr   <= {redirect_pc[31:2], 2'b00};
			hw_buf_valid <= 1'b0;
			instr_req    <= 1'b0;
			// Finish an open word handshake and drop its data
			if (state == AL_FETCH && !word_ack) begin
				discard <= 1'b1;
			end else begin
				word_req <= 1'b0;
				discard  <= 1'b0;
				state    <= AL_IDLE;
			end
		end else begin
			case (state)
				AL_IDLE: begin
					if (issue_buf) begin
						instr_req    <= 1'b1;
						hw_buf_valid <= 1'b0;
						state        <= AL_OUTPUT;
					end else if (start_fetch) begin
						word_req   <= 1'b1;
						fetch_addr <= fetch_addr + 32'd4;
						state      <= AL_FETCH;
					end
				end
				AL_FETCH: begin
					if (word_ack && discard) begin
						word_req <= 1'b0;
						discard  <= 1'b0;
						state    <= AL_IDLE;
					end else if (take_word) begin
						word_req     <= 1'b0;
						hw_buf_valid <= asm_buf_valid;
						if (asm_done) begin
							instr_req <= 1'b1;
							state     <= AL_OUTPUT;
						end else begin
							state <= AL_IDLE;
						end
					end
				end
				AL_OUTPUT: begin
					// Step past the accepted instruction
					if (instr_ack) begin
						instr_req <= 1'b0;
						pc        <= pc + instr_len_bytes(instr[15:0]);
						state     <= AL_IDLE;
					end
				end
				default: state <= AL_IDLE;
			endcase
		end
	end

	// Word address, instruction and parcel buffer
	always_ff @(posedge clk) begin
		if (start_fetch)
			word_addr <= fetch_addr;
		if (issue_buf)
			instr <= {16'h0000, hw_buf};
		if (take_word) begin
			instr  <= asm_instr;
			hw_buf <= word_data[31:16];
		end
	end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
	parameter fetch_pkg::addr_t RESET_PC       = '0,
	parameter int               ICACHE_ENTRIES = 8
) (
	input  wire                     clk,
	input  wire                     rst_n,
	// Fetch restart
	input  wire                     redirect,
	input  wire fetch_pkg::addr_t   redirect_pc,
	// External memory bus
	output logic                    mem_req,
	output fetch_pkg::addr_t        mem_addr,
	input  wire                     mem_ack,
	input  wire fetch_pkg::word_t   mem_rdata,
	// Instruction port
	output logic                    instr_req,
	output fetch_pkg::instr_t       instr,
	output fetch_pkg::addr_t        instr_pc,
	output logic                    instr_is_32bit,
	input  wire                     instr_ack
);
	import fetch_pkg::*;

	// Cache to bus master
	logic  fill_req;
	addr_t fill_addr;
	logic  fill_ack;
	word_t fill_data;

	// Aligner to cache
	logic  word_req;
	addr_t word_addr;
	logic  word_ack;
	word_t word_data;

	// ========================================================================
	// Memory side
	// ========================================================================

	fetch_bus_master u_bus_master (
		.clk       (clk),
		.rst_n     (rst_n),
		.fill_req  (fill_req),
		.fill_addr (fill_addr),
		.fill_ack  (fill_ack),
		.fill_data (fill_data),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	icache_ro_assoc #(
		.ICACHE_ENTRIES (ICACHE_ENTRIES)
	) u_icache (
		.clk       (clk),
		.rst_n     (rst_n),
		.word_req  (word_req),
		.word_addr (word_addr),
		.word_ack  (word_ack),
		.word_data (word_data),
		.fill_req  (fill_req),
		.fill_addr (fill_addr),
		.fill_ack  (fill_ack),
		.fill_data (fill_data)
	);

	// ========================================================================
	// Instruction side
	// ========================================================================

	instr_aligner #(
		.RESET_PC (RESET_PC)
	) u_aligner (
		.clk            (clk),
		.rst_n          (rst_n),
		.redirect       (redirect),
		.redirect_pc    (redirect_pc),
		.word_req       (word_req),
		.word_addr      (word_addr),
		.word_ack       (word_ack),
		.word_data      (word_data),
		.instr_req      (instr_req),
		.instr          (instr),
		.instr_pc       (instr_pc),
		.instr_is_32bit (instr_is_32bit),
		.instr_ack      (instr_ack)
	);

endmodule

`default_nettype wire

// File: bench/tb_fetch_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_asserts (
	input wire                    clk,
	input wire                    rst_n,
	input wire                    mem_req,
	input wire fetch_pkg::addr_t  mem_addr,
	input wire                    mem_ack,
	input wire                    fill_req,
	input wire                    fill_ack,
	input wire                    word_req,
	input wire                    word_ack,
	input wire                    instr_req,
	input wire fetch_pkg::instr_t instr,
	input wire fetch_pkg::addr_t  instr_pc,
	input wire                    instr_is_32bit,
	input wire                    instr_ack
);

	// ========================================================================
	// Memory bus
	// ========================================================================

	// Address held for the whole request
	a_mem_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && $past(mem_req) |-> $stable(mem_addr))
		else $error("mem_addr changed while mem_req was high");

	a_mem_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req |-> mem_addr[1:0] == 2'b00)
		else $error("mem_addr is not word aligned");

	// ========================================================================
	// Instruction port
	// ========================================================================

	a_instr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		instr_req && $past(instr_req) |->
			$stable(instr) && $stable(instr_pc) && $stable(instr_is_32bit))
		else $error("instruction outputs changed while instr_req was high");

	// ========================================================================
	// Four-phase rule, a req rises only once its ack has fallen
	// ========================================================================

	a_mem_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_req) |-> !$past(mem_ack))
		else $error("mem_req rose while mem_ack was high");

	a_fill_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(fill_req) |-> !$past(fill_ack))
		else $error("fill_req rose while fill_ack was high");

	a_word_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(word_req) |-> !$past(word_ack))
		else $error("word_req rose while word_ack was high");

	a_instr_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(instr_req) |-> !$past(instr_ack))
		else $error("instr_req rose while instr_ack was high");

endmodule

// Internal fill and word handshakes are wires of fetch_top
bind fetch_top tb_fetch_asserts u_asserts (
	.clk            (clk),
	.rst_n          (rst_n),
	.mem_req        (mem_req),
	.mem_addr       (mem_addr),
	.mem_ack        (mem_ack),
	.fill_req       (fill_req),
	.fill_ack       (fill_ack),
	.word_req       (word_req),
	.word_ack       (word_ack),
	.instr_req      (instr_req),
	.instr          (instr),
	.instr_pc       (instr_pc),
	.instr_is_32bit (instr_is_32bit),
	.instr_ack      (instr_ack)
);

`default_nettype wire

// File: bench/tb_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch;
	import fetch_pkg::*;

	localparam int unsigned WAIT_LIMIT = 3000;
	// Regions with tags never touched by the earlier phases
	localparam addr_t       HIT_BASE   = 32'h0000_1000;
	localparam addr_t       SLOW_BASE  = 32'h0000_2000;

	logic   clk = 1'b0;
	logic   rst_n;
	logic   redirect;
	addr_t  redirect_pc;
	logic   mem_req;
	addr_t  mem_addr;
	logic   mem_ack;
	word_t  mem_rdata;
	logic   instr_req;
	instr_t instr;
	addr_t  instr_pc;
	logic   instr_is_32bit;
	logic   instr_ack;

	// Memory image, indexed by word address modulo 256
	word_t       mem [256];
	int unsigned mem_transfers;
	int unsigned mem_delay_max;
	int unsigned ack_delay_max;
	// Reference model
	addr_t       model_pc;
	int unsigned straddles;
	string       test_name;

	fetch_top #(
		.RESET_PC       (32'h0000_0000),
		.ICACHE_ENTRIES (8)
	) u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.redirect       (redirect),
		.redirect_pc    (redirect_pc),
		.mem_req        (mem_req),
		.mem_addr       (mem_addr),
		.mem_ack        (mem_ack),
		.mem_rdata      (mem_rdata),
		.instr_req      (instr_req),
		.instr          (instr),
		.instr_pc       (instr_pc),
		.instr_is_32bit (instr_is_32bit),
		.instr_ack      (instr_ack)
	);

	always #20 clk = ~clk;

	// ========================================================================
	// Helpers and compare tasks
	// ========================================================================

	// Drive slot, just after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_instr(input string what, input instr_t exp, input instr_t act);
		if (exp !== act)
			abort_run($sformatf("ERR %s %s: expected %h, actual %h", test_name, what, exp, act));
	endtask

	task automatic check_addr(input string what, input addr_t exp, input addr_t act);
		if (exp !== act)
			abort_run($sformatf("ERR %s %s: expected %h, actual %h", test_name, what, exp, act));
	endtask

	task automatic check_flag(input string what, input bit exp, input bit act);
		if (exp !== act)
			abort_run($sformatf("ERR %s %s: expected %b, actual %b", test_name, what, exp, act));
	endtask

	function automatic half_t parcel_at(input addr_t a);
		word_t w;
		w = mem[a[9:2]];
		return a[1] ? w[31:16] : w[15:0];
	endfunction

	// RISC-V length rule, low bits 11 open a 32-bit instruction
	function automatic bit parcel_is_long(input half_t p);
		return p[1] && p[0];
	endfunction

	function automatic half_t random_parcel();
		logic [31:0] r;
		half_t       p;
		r = $urandom;
		p = r[15:0];
		// Roughly half the parcels start a 32-bit instruction
		if (r[16])
			p[1:0] = 2'b11;
		else if (p[1:0] == 2'b11)
			p[1:0] = 2'b01;
		return p;
	endfunction

	// ========================================================================
	// Instruction consumer with model check
	// ========================================================================

	task automatic take_instr();
		int unsigned cnt;
		int unsigned delay;
		half_t       lo;
		bit          exp_long;
		instr_t      exp_instr;
		cnt = 0;
		while (!instr_req) begin
			step();
			cnt++;
			if (cnt > WAIT_LIMIT)
				abort_run("Timeout waiting for an instruction request");
		end
		lo        = parcel_at(model_pc);
		exp_long  = parcel_is_long(lo);
		exp_instr = exp_long ? {parcel_at(model_pc + 32'd2), lo} : {16'h0000, lo};
		check_addr("instr_pc", model_pc, instr_pc);
		check_flag("instr_is_32bit", exp_long, instr_is_32bit);
		check_instr(exp_long && model_pc[1] ? "straddled instr" : "instr", exp_instr, instr);
		if (exp_long && model_pc[1])
			straddles++;
		model_pc = model_pc + (exp_long ? 32'd4 : 32'd2);
		// Back-pressure on the instruction port
		delay = $urandom_range(ack_delay_max, 0);
		repeat (delay) step();
		instr_ack = 1'b1;
		cnt = 0;
		while (instr_req) begin
			step();
			cnt++;
			if (cnt > WAIT_LIMIT)
				abort_run("Timeout waiting for instr_req to drop after ack");
		end
		instr_ack = 1'b0;
	endtask

	// Pulse redirect, possibly while a word fetch is in flight
	task automatic redirect_to(input addr_t target);
		int unsigned gap;
		gap = $urandom_range(3, 0);
		while (gap > 0 && !instr_req) begin
			step();
			gap--;
		end
		// Instruction already offered on the old path goes first
		if (instr_req)
			take_instr();
		redirect    = 1'b1;
		redirect_pc = target;
		model_pc    = target;
		step();
		redirect    = 1'b0;
	endtask

	// ========================================================================
	// Memory responder
	// ========================================================================

	initial begin : memory_responder
		int unsigned delay;
		int unsigned cnt;
		forever begin
			step();
			if (rst_n && mem_req && !mem_ack) begin
				delay = $urandom_range(mem_delay_max, 0);
				repeat (delay) step();
				mem_rdata = mem[mem_addr[9:2]];
				mem_ack   = 1'b1;
				mem_transfers++;
				cnt = 0;
				while (mem_req) begin
					step();
					cnt++;
					if (cnt > WAIT_LIMIT)
						abort_run("Timeout waiting for mem_req to drop after ack");
				end
				mem_ack = 1'b0;
			end
		end
	end

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin : main_flow
		int unsigned r;
		int unsigned count;
		int unsigned snap;
		addr_t       target;
		void'($urandom(32'haf4d5b4a));
		rst_n         = 1'b0;
		redirect      = 1'b0;
		redirect_pc   = '0;
		mem_ack       = 1'b0;
		mem_rdata     = '0;
		instr_ack     = 1'b0;
		mem_transfers = 0;
		mem_delay_max = 4;
		ack_delay_max = 3;
		straddles     = 0;
		model_pc      = 32'h0000_0000;
		for (int i = 0; i < 256; i++)
			mem[i] = {random_parcel(), random_parcel()};
		repeat (8) step();
		rst_n = 1'b1;

		// Straight-line fetch from the reset pc
		test_name = "sequential";
		repeat (300) take_instr();
		test_name = "straddle";
		if (straddles < 10)
			abort_run("Too few straddling 32-bit instructions were seen");

		// Every other target starts on an odd halfword
		test_name = "redirect";
		for (int n = 0; n < 24; n++) begin
			r      = $urandom_range(511, 0);
			target = {r[30:0], 1'b0};
			if (n % 2 == 1)
				target[1] = 1'b1;
			redirect_to(target);
			count = $urandom_range(10, 3);
			repeat (count) take_instr();
		end

		// Walk five fresh words, then walk them again from the cache
		test_name = "cache_hit";
		redirect_to(HIT_BASE);
		while (model_pc < HIT_BASE + 32'd16)
			take_instr();
		redirect_to(HIT_BASE);
		// A discarded fetch of the old path settles before this one
		take_instr();
		snap = mem_transfers;
		while (model_pc < HIT_BASE + 32'd12) begin
			take_instr();
			if (mem_transfers != snap)
				abort_run("Memory transfer while re-walking cached words");
		end
		while (model_pc < HIT_BASE + 32'd48)
			take_instr();
		if (mem_transfers == snap)
			abort_run("No memory transfer after leaving the cached words");

		// Slow memory and a slow consumer
		test_name     = "back_pressure";
		ack_delay_max = 15;
		mem_delay_max = 12;
		redirect_to(SLOW_BASE);
		repeat (120) take_instr();
		redirect_to(SLOW_BASE + 32'd6);
		repeat (40) take_instr();

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
hw/fetch_pkg.sv
hw/fetch_bus_master.sv
hw/icache_ro_assoc.sv
hw/instr_aligner.sv
hw/fetch_top.sv
bench/tb_fetch_asserts.sv
bench/tb_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_fetch -o tb_fetch_sim

# The simulation log decides the result
./obj_dir/tb_fetch_sim 2>&1 | tee "$LOG"

if grep -q "Test completed successfully" "$LOG"; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
